// ==== src/lsu_pkg.sv ====
package lsu_pkg;

	// bytes carried by one bus beat
	localparam int BEAT_BYTES = 8;

	// ------------------------------
	// widths with a meaning
	// ------------------------------
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [BEAT_BYTES*8-1:0] dword_t;
	typedef logic [BEAT_BYTES-1:0] strb_t;
	typedef logic [4:0] reg_idx_t;

	typedef enum logic [3:0] {
		OP_LW,
		OP_LH,
		OP_LHU,
		OP_LB,
		OP_LBU,
		OP_SW,
		OP_SH,
		OP_SB
	} mem_op_e;

	// ------------------------------
	// command, result and bus payloads
	// ------------------------------
	typedef struct packed {
		mem_op_e  op;
		addr_t    addr;
		word_t    wdata;
		reg_idx_t rd;
	} lsu_cmd_t;

	// data is zero for stores
	typedef struct packed {
		reg_idx_t rd;
		word_t    data;
	} lsu_rsp_t;

	// shared by read and write address channels
	typedef struct packed {
		addr_t addr;
	} bus_addr_t;

	typedef struct packed {
		dword_t data;
		strb_t  strb;
	} bus_wdata_t;

	function automatic logic op_is_store(mem_op_e op);
		return op inside {OP_SW, OP_SH, OP_SB};
	endfunction

endpackage

// ==== src/lsu_request_slot.sv ====
`timescale 1ns/100ps
module lsu_request_slot (
	input  logic              clock,
	input  logic              reset,
	input  logic              cmd_req,
	input  lsu_pkg::lsu_cmd_t cmd,
	output logic              cmd_ack,
	output logic              rsp_req,
	output lsu_pkg::lsu_rsp_t rsp,
	input  logic              rsp_ack,
	output lsu_pkg::lsu_cmd_t held_cmd,
	output logic              start,
	input  logic              access_done,
	input  lsu_pkg::word_t    load_data
);
	import lsu_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_ACKING, S_BUSY, S_RESPONDING} slot_state_e;

	slot_state_e state;

	// command held for the whole access
	always_ff @(posedge clock) begin
		if (state == S_IDLE && cmd_req && !cmd_ack) begin
			held_cmd <= cmd;
		end
	end

	// result captured when the bus side finishes
	always_ff @(posedge clock) begin
		if (state == S_BUSY && access_done) begin
			rsp.rd   <= held_cmd.rd;
			rsp.data <= op_is_store(held_cmd.op) ? '0 : load_data;
		end
	end

	// ------------------------------
	// handshake sequencing
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= S_IDLE;
			cmd_ack <= 1'b0;
			rsp_req <= 1'b0;
			start   <= 1'b0;
		end else begin
			start <= 1'b0;
			// ack falls once the requester lets go
			if (cmd_ack && !cmd_req) begin
				cmd_ack <= 1'b0;
			end
			case (state)
				S_IDLE: begin
					if (cmd_req && !cmd_ack) begin
						cmd_ack <= 1'b1;
						state   <= S_ACKING;
					end
				end
				S_ACKING: begin
					start <= 1'b1;
					state <= S_BUSY;
				end
				S_BUSY: begin
					if (access_done) begin
						rsp_req <= 1'b1;
						state   <= S_RESPONDING;
					end
				end
				S_RESPONDING: begin
					// idle again only after rsp_ack has dropped
					if (rsp_req && rsp_ack) begin
						rsp_req <= 1'b0;
					end else if (!rsp_req && !rsp_ack) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== src/lsu_beat_planner.sv ====
`timescale 1ns/100ps
module lsu_beat_planner (
	input  lsu_pkg::lsu_cmd_t held_cmd,
	output lsu_pkg::addr_t    first_addr,
	output lsu_pkg::addr_t    second_addr,
	output lsu_pkg::strb_t    first_strb,
	output lsu_pkg::strb_t    second_strb,
	output lsu_pkg::dword_t   wdata,
	output logic              need_second
);
	import lsu_pkg::*;

	logic [2:0]                  off;
	logic                        is_word;
	logic                        is_half;
	logic [3:0]                  size_mask;
	logic [11:0]                 span;
	strb_t                       word_lanes;
	logic [2*BEAT_BYTES*8-1:0]   wdata_twice;

	assign off     = held_cmd.addr[2:0];
	assign is_word = held_cmd.op inside {OP_LW, OP_SW};
	assign is_half = held_cmd.op inside {OP_LH, OP_LHU, OP_SH};

	assign size_mask = is_word ? 4'b1111 : (is_half ? 4'b0011 : 4'b0001);

	// ------------------------------
	// beat addresses
	// ------------------------------
	assign first_addr = {held_cmd.addr[31:2], 2'b00};
	// next word, which is the next doubleword for offsets 5..7
	assign second_addr = first_addr + addr_t'(4);

	// access runs past the end of its aligned word
	assign need_second = (is_word && off[1:0] != 2'b00) ||
		(is_half && off[1:0] == 2'b11);

	// ------------------------------
	// byte strobes
	// ------------------------------
	// bytes touched, counted from lane 0 of the first beat
	assign span       = 12'(size_mask) << off;
	assign word_lanes = off[2] ? 8'hf0 : 8'h0f;
	assign first_strb = span[7:0] & word_lanes;

	always_comb begin
		second_strb = '0;
		if (need_second) begin
			// spill from the upper word wraps into lanes 0..3 of the next dword
			if (off[2]) begin
				second_strb = {4'b0000, span[11:8]};
			end else begin
				second_strb = {span[7:4], 4'b0000};
			end
		end
	end

	// store word rotated left into its lane, both beats share it
	assign wdata_twice = {2{dword_t'(held_cmd.wdata)}} << {off, 3'b000};
	assign wdata       = wdata_twice[2*BEAT_BYTES*8-1 -: BEAT_BYTES*8];

endmodule

// ==== src/lsu_bus_master.sv ====
`timescale 1ns/100ps
module lsu_bus_master #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 64
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                start,
	input  logic                is_store,
	input  logic                need_second,
	input  lsu_pkg::addr_t      first_addr,
	input  lsu_pkg::addr_t      second_addr,
	input  lsu_pkg::strb_t      first_strb,
	input  lsu_pkg::strb_t      second_strb,
	input  lsu_pkg::dword_t     wdata,
	output logic                ar_valid,
	output lsu_pkg::bus_addr_t  ar,
	input  logic                ar_ready,
	input  logic                r_valid,
	output logic                r_ready,
	output logic                aw_valid,
	output lsu_pkg::bus_addr_t  aw,
	input  logic                aw_ready,
	output logic                w_valid,
	output lsu_pkg::bus_wdata_t w,
	input  logic                w_ready,
	input  logic                b_valid,
	output logic                b_ready,
	output logic                beat_taken,
	output logic                beat_index,
	output logic                access_done
);
	typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} rd_state_e;
	typedef enum logic [1:0] {W_IDLE, W_ADDR, W_DATA, W_RESP} wr_state_e;

	rd_state_e           rd_state;
	wr_state_e           wr_state;
	logic                rd_second;
	logic                wr_second;
	logic [ADDR_W-1:0]   rd_addr;
	logic [ADDR_W-1:0]   wr_addr;
	logic [DATA_W/8-1:0] wr_strb;
	logic                r_fire;
	logic                b_fire;

	assign r_fire = r_valid && r_ready;
	assign b_fire = b_valid && b_ready;

	// ------------------------------
	// read side
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_state  <= R_IDLE;
			rd_second <= 1'b0;
		end else begin
			case (rd_state)
				R_IDLE: begin
					if (start && !is_store) begin
						rd_state  <= R_ADDR;
						rd_second <= 1'b0;
					end
				end
				R_ADDR: begin
					if (ar_ready) begin
						rd_state <= R_DATA;
					end
				end
				R_DATA: begin
					if (r_fire && need_second && !rd_second) begin
						rd_second <= 1'b1;
						rd_state  <= R_ADDR;
					end else if (r_fire) begin
						rd_state <= R_IDLE;
					end
				end
				default: rd_state <= R_IDLE;
			endcase
		end
	end

	assign rd_addr    = rd_second ? second_addr : first_addr;
	assign ar_valid   = (rd_state == R_ADDR);
	assign ar         = '{addr: rd_addr};
	assign r_ready    = (rd_state == R_DATA);
	assign beat_taken = r_fire;
	assign beat_index = rd_second;

	// ------------------------------
	// write side
	// ------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_state  <= W_IDLE;
			wr_second <= 1'b0;
		end else begin
			case (wr_state)
				W_IDLE: begin
					if (start && is_store) begin
						wr_state  <= W_ADDR;
						wr_second <= 1'b0;
					end
				end
				W_ADDR: begin
					if (aw_ready) begin
						wr_state <= W_DATA;
					end
				end
				// data only after the address went through
				W_DATA: begin
					if (w_ready) begin
						wr_state <= W_RESP;
					end
				end
				W_RESP: begin
					if (b_fire && need_second && !wr_second) begin
						wr_second <= 1'b1;
						wr_state  <= W_ADDR;
					end else if (b_fire) begin
						wr_state <= W_IDLE;
					end
				end
				default: wr_state <= W_IDLE;
			endcase
		end
	end

	assign wr_addr  = wr_second ? second_addr : first_addr;
	assign wr_strb  = wr_second ? second_strb : first_strb;
	assign aw_valid = (wr_state == W_ADDR);
	assign aw       = '{addr: wr_addr};
	assign w_valid  = (wr_state == W_DATA);
	assign w        = '{data: wdata, strb: wr_strb};
	assign b_ready  = (wr_state == W_RESP);

	// one cycle after the final read beat or write response
	always_ff @(posedge clock) begin
		if (reset) begin
			access_done <= 1'b0;
		end else begin
			access_done <= (r_fire && (rd_second || !need_second)) ||
				(b_fire && (wr_second || !need_second));
		end
	end

endmodule

// ==== src/lsu_load_merge.sv ====
`timescale 1ns/100ps
module lsu_load_merge #(
	parameter int DATA_W = 64
) (
	input  logic              clock,
	input  logic              reset,
	input  lsu_pkg::lsu_cmd_t held_cmd,
	input  lsu_pkg::strb_t    first_strb,
	input  lsu_pkg::strb_t    second_strb,
	input  lsu_pkg::dword_t   r_data,
	input  logic              beat_taken,
	input  logic              beat_index,
	output lsu_pkg::word_t    load_data
);
	import lsu_pkg::*;

	logic [DATA_W-1:0]   first_beat;
	logic [DATA_W-1:0]   first_src;
	logic [DATA_W-1:0]   merged;
	logic [2*DATA_W-1:0] rotated;
	word_t               raw;
	word_t               extended;
	logic                last_beat;

	// first beat parked until its partner arrives
	always_ff @(posedge clock) begin
		if (beat_taken && !beat_index && second_strb != '0) begin
			first_beat <= r_data;
		end
	end

	assign first_src = beat_index ? first_beat : r_data;

	// each lane comes from whichever beat enabled it
	always_comb begin
		merged = '0;
		for (int i = 0; i < DATA_W/8; i++) begin
			if (first_strb[i]) begin
				merged[i*8 +: 8] = first_src[i*8 +: 8];
			end else if (second_strb[i]) begin
				merged[i*8 +: 8] = r_data[i*8 +: 8];
			end
		end
	end

	// rotate right so the addressed byte lands in bits 7:0
	assign rotated = {merged, merged} >> {held_cmd.addr[2:0], 3'b000};
	assign raw     = rotated[31:0];

	always_comb begin
		case (held_cmd.op)
			OP_LH:   extended = {{16{raw[15]}}, raw[15:0]};
			OP_LHU:  extended = {16'h0000, raw[15:0]};
			OP_LB:   extended = {{24{raw[7]}}, raw[7:0]};
			OP_LBU:  extended = {24'h000000, raw[7:0]};
			default: extended = raw;
		endcase
	end

	assign last_beat = beat_taken && (beat_index || second_strb == '0);

	// holds from access_done until the next load finishes
	always_ff @(posedge clock) begin
		if (reset) begin
			load_data <= '0;
		end else if (last_beat) begin
			load_data <= extended;
		end
	end

endmodule

// ==== src/lsu_top.sv ====
`timescale 1ns/100ps
module lsu_top #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 64
) (
	input  logic                clock,
	input  logic                reset,
	// command and result ports
	input  logic                cmd_req,
	input  lsu_pkg::lsu_cmd_t   cmd,
	output logic                cmd_ack,
	output logic                rsp_req,
	output lsu_pkg::lsu_rsp_t   rsp,
	input  logic                rsp_ack,
	// read channels
	output logic                ar_valid,
	output lsu_pkg::bus_addr_t  ar,
	input  logic                ar_ready,
	input  logic                r_valid,
	input  lsu_pkg::dword_t     r_data,
	output logic                r_ready,
	// write channels
	output logic                aw_valid,
	output lsu_pkg::bus_addr_t  aw,
	input  logic                aw_ready,
	output logic                w_valid,
	output lsu_pkg::bus_wdata_t w,
	input  logic                w_ready,
	input  logic                b_valid,
	output logic                b_ready
);
	import lsu_pkg::*;

	lsu_cmd_t held_cmd;
	logic     start;
	logic     is_store;
	addr_t    first_addr;
	addr_t    second_addr;
	strb_t    first_strb;
	strb_t    second_strb;
	dword_t   wdata;
	logic     need_second;
	logic     beat_taken;
	logic     beat_index;
	logic     access_done;
	word_t    load_data;

	// picks the write or read state machine
	assign is_store = op_is_store(held_cmd.op);

	lsu_request_slot u_slot (.*);

	lsu_beat_planner u_planner (.*);

	lsu_bus_master #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W)
	) u_master (.*);

	lsu_load_merge #(
		.DATA_W(DATA_W)
	) u_merge (.*);

endmodule

// ==== sim/lsu_checker.sv ====
`timescale 1ns/100ps
module lsu_checker (
	input  logic              clock,
	input  logic              reset,
	input  logic              cmd_ack,
	input  logic              rsp_req,
	input  lsu_pkg::lsu_rsp_t rsp,
	input  logic              rsp_ack,
	output int                checked,
	output int                mismatches,
	output int                protocol_errors
);
	import lsu_pkg::*;

	reg_idx_t exp_rd[$];
	word_t    exp_data[$];
	logic     cmd_ack_prev;
	logic     rsp_req_prev;
	logic     rsp_ack_prev;
	lsu_rsp_t rsp_prev;
	logic     in_flight;

	// expected rd and data of every test
	initial begin
		int          fd;
		string       line;
		logic [31:0] f_op, f_rd, f_addr, f_data, f_exp;
		fd = $fopen("sim/lsu_vectors.txt", "r");
		if (fd == 0) begin
			$display("checker could not open sim/lsu_vectors.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin
					if ($sscanf(line, "%h %h %h %h %h",
						f_op, f_rd, f_addr, f_data, f_exp) == 5) begin
						exp_rd.push_back(f_rd[4:0]);
						exp_data.push_back(f_exp);
					end
				end
			end
			$fclose(fd);
		end
	end

	task automatic check_result();
		if (checked >= exp_rd.size()) begin
			$display("Error at %0t: result for rd %0d arrived with no test left",
				$time, rsp.rd);
			protocol_errors++;
		end else if (rsp.rd != exp_rd[checked] || rsp.data != exp_data[checked]) begin
			$display("Mismatch at %0t: test %0d expected rd %0d data %h, got rd %0d data %h",
				$time, checked, exp_rd[checked], exp_data[checked], rsp.rd, rsp.data);
			mismatches++;
		end else begin
			$display("test %0d passed: rd %0d data %h", checked, rsp.rd, rsp.data);
		end
		checked++;
	endtask

	// sampled on the rising edge, before the DUT updates
	always @(posedge clock) begin
		if (reset) begin
			checked         = 0;
			mismatches      = 0;
			protocol_errors = 0;
			in_flight       = 1'b0;
		end else begin
			// previous command is finished once rsp_ack drops
			if (rsp_ack_prev && !rsp_ack) begin
				in_flight = 1'b0;
			end
			if (cmd_ack && !cmd_ack_prev) begin
				if (in_flight) begin
					$display("Error at %0t: cmd_ack rose before the previous result was taken",
						$time);
					protocol_errors++;
				end
				in_flight = 1'b1;
			end
			if (rsp_req && !rsp_req_prev) begin
				check_result();
			end else if (rsp_req && rsp_req_prev && rsp != rsp_prev) begin
				$display("Error at %0t: rsp changed while rsp_req was high", $time);
				protocol_errors++;
			end
		end
		cmd_ack_prev = cmd_ack;
		rsp_req_prev = rsp_req;
		rsp_ack_prev = rsp_ack;
		rsp_prev     = rsp;
	end

endmodule

// ==== sim/tb_lsu.sv ====
`timescale 1ns/100ps
module tb_lsu;
	import lsu_pkg::*;

	localparam int ns_per_vector = 200;

	logic       clock = 1'b0;
	logic       reset = 1'b1;
	logic       cmd_req = 1'b0;
	lsu_cmd_t   cmd = '0;
	logic       cmd_ack;
	logic       rsp_req;
	lsu_rsp_t   rsp;
	logic       rsp_ack = 1'b0;
	logic       ar_valid;
	bus_addr_t  ar;
	logic       ar_ready = 1'b0;
	logic       r_valid = 1'b0;
	dword_t     r_data = '0;
	logic       r_ready;
	logic       aw_valid;
	bus_addr_t  aw;
	logic       aw_ready = 1'b0;
	logic       w_valid;
	bus_wdata_t w;
	logic       w_ready = 1'b0;
	logic       b_valid = 1'b0;
	logic       b_ready;

	int         checked;
	int         mismatches;
	int         protocol_errors;
	int         format_errors = 0;
	int         bus_errors;
	bit         loaded = 1'b0;
	lsu_cmd_t   cmds[$];

	// memory model state
	integer     seed = 32'he81ed913;
	logic [7:0] mem [0:1023];
	addr_t      rd_pending[$];
	addr_t      wr_pending[$];
	logic       r_will_fire;
	logic       b_will_fire;
	int         b_owed;
	int         rsp_wait;

	lsu_top u_lsu_top (.*);

	lsu_checker u_checker (.*);

	initial begin
		forever #5 clock = ~clock;
	end

	// ready about three cycles in four
	function automatic logic ready_draw();
		return ($random(seed) & 3) != 0;
	endfunction

	function automatic dword_t read_dword(addr_t a);
		dword_t d;
		for (int i = 0; i < BEAT_BYTES; i++) begin
			d[i*8 +: 8] = mem[{a[9:3], i[2:0]}];
		end
		return d;
	endfunction

	function automatic void write_dword(addr_t a, dword_t d, strb_t s);
		for (int i = 0; i < BEAT_BYTES; i++) begin
			if (s[i]) begin
				mem[{a[9:3], i[2:0]}] = d[i*8 +: 8];
			end
		end
	endfunction

	task automatic load_vectors(output bit ok);
		int          fd;
		string       line;
		logic [31:0] f_op, f_rd, f_addr, f_data, f_exp;
		lsu_cmd_t    c;
		fd = $fopen("sim/lsu_vectors.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin
					if ($sscanf(line, "%h %h %h %h %h",
						f_op, f_rd, f_addr, f_data, f_exp) == 5) begin
						c.op    = mem_op_e'(f_op[3:0]);
						c.addr  = f_addr;
						c.wdata = f_data;
						c.rd    = f_rd[4:0];
						cmds.push_back(c);
					end else begin
						$display("vector line could not be read: %s", line);
						format_errors++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// four-phase command handshake, entered and left on a falling edge
	task automatic send_command(lsu_cmd_t c);
		cmd     = c;
		cmd_req = 1'b1;
		do begin
			@(negedge clock);
		end while (!cmd_ack);
		cmd_req = 1'b0;
		do begin
			@(negedge clock);
		end while (cmd_ack);
	endtask

	// ------------------------------
	// bus memory and result acks
	// ------------------------------
	// a transfer decided here happens on the next rising edge
	always @(negedge clock) begin
		if (reset) begin
			for (int i = 0; i < 1024; i++) begin
				mem[i[9:0]] = 8'h00;
			end
			rd_pending.delete();
			wr_pending.delete();
			r_will_fire = 1'b0;
			b_will_fire = 1'b0;
			b_owed      = 0;
			rsp_wait    = 0;
			bus_errors  = 0;
		end else begin
			if (r_will_fire) begin
				void'(rd_pending.pop_front());
				r_valid = 1'b0;
			end
			if (!r_valid && rd_pending.size() != 0 && ready_draw()) begin
				r_valid = 1'b1;
				r_data  = read_dword(rd_pending[0]);
			end
			r_will_fire = r_valid && r_ready;
			ar_ready = ready_draw();
			if (ar_valid && ar_ready) begin
				rd_pending.push_back(ar.addr);
			end

			if (b_will_fire) begin
				b_valid = 1'b0;
				b_owed--;
			end
			if (!b_valid && b_owed != 0 && ready_draw()) begin
				b_valid = 1'b1;
			end
			b_will_fire = b_valid && b_ready;
			aw_ready = ready_draw();
			if (aw_valid && aw_ready) begin
				wr_pending.push_back(aw.addr);
			end
			w_ready = ready_draw();
			if (w_valid && w_ready) begin
				if (wr_pending.size() == 0) begin
					$display("Error at %0t: write data offered before its address", $time);
					bus_errors++;
				end else begin
					write_dword(wr_pending.pop_front(), w.data, w.strb);
					b_owed++;
				end
			end

			// late rsp_ack, up to three cycles
			if (rsp_ack) begin
				if (!rsp_req) begin
					rsp_ack = 1'b0;
				end
			end else if (rsp_req) begin
				if (rsp_wait == 0) begin
					rsp_ack = 1'b1;
				end else begin
					rsp_wait--;
				end
			end else begin
				rsp_wait = $random(seed) & 3;
			end
		end
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		bit ok;
		load_vectors(ok);
		if (!ok) begin
			$display("could not open the vector file sim/lsu_vectors.txt");
			$display("Simulation FAILED");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (4) @(posedge clock);
			@(negedge clock);
			reset <= 1'b0;
			foreach (cmds[i]) begin
				send_command(cmds[i]);
			end
			while (checked < cmds.size()) begin
				@(negedge clock);
			end
			$display("%0d tests, %0d passed, %0d mismatched, %0d other errors",
				checked, checked - mismatches, mismatches,
				protocol_errors + bus_errors + format_errors);
			if (checked == cmds.size() && mismatches == 0 && protocol_errors == 0 &&
				bus_errors == 0 && format_errors == 0) begin
				$display("Simulation PASSED");
			end else begin
				$display("Simulation FAILED");
			end
			$finish;
		end
	end

	// watchdog scaled by the number of tests
	initial begin
		wait (loaded && !reset);
		#(cmds.size() * ns_per_vector);
		$display("timeout: only %0d of %0d results arrived within %0d ns",
			checked, cmds.size(), cmds.size() * ns_per_vector);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
src/lsu_pkg.sv
src/lsu_request_slot.sv
src/lsu_beat_planner.sv
src/lsu_bus_master.sv
src/lsu_load_merge.sv
src/lsu_top.sv
sim/lsu_checker.sv
sim/tb_lsu.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_lsu -f compile.f -o sim_lsu
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_lsu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Simulation PASSED$"; then
	exit 0
fi
exit 1

// ==== sim/lsu_vectors.txt ====
# columns: op rd addr wdata expected, all hex
# op 0 lw, 1 lh, 2 lhu, 3 lb, 4 lbu, 5 sw, 6 sh, 7 sb; expected is 0 for stores
5 01 00000010 12345678 00000000
0 02 00000010 00000000 12345678
7 03 00000011 ffffffab 00000000
6 04 00000012 eeeecafe 00000000
0 05 00000010 00000000 cafeab78
5 06 00000025 deadbeef 00000000
0 07 00000025 00000000 deadbeef
3 08 00000027 00000000 ffffffad
4 09 00000027 00000000 000000ad
1 0a 00000027 00000000 ffffdead
2 0b 00000027 00000000 0000dead
1 0c 00000025 00000000 ffffbeef
3 0d 00000010 00000000 00000078
1 0e 00000011 00000000 fffffeab
5 0f 00000033 89abcdef 00000000
0 10 00000033 00000000 89abcdef
6 11 0000003b 00008001 00000000
1 12 0000003b 00000000 ffff8001
0 13 00000026 00000000 00deadbe
4 14 00000036 00000000 00000089
